// ==== logic/sram_console_defs.svh ====
`ifndef SRAM_CONSOLE_DEFS_SVH
`define SRAM_CONSOLE_DEFS_SVH

// SRAM data width, also the console character width
`define DATA_W 8

// SRAM address width; entered addresses only fill the low bits
`define ADDR_W 19

// characters taken per entered field
`define DIGITS 8

// print item queue depth
`define TXQ_DEPTH 16

// cycles of tx_ready high before a character may start
`define TX_HOLD 8

`endif

// ==== logic/sram_console_pkg.sv ====
`include "sram_console_defs.svh"

package sram_console_pkg;

  typedef enum logic [3:0] {
    show_menu,     // push the menu text
    wait_option,   // wait for "1" or "2"
    prompt_data,
    get_data,
    prompt_addr,
    get_addr,
    do_write,      // one-cycle sram write
    prompt_read,
    get_read_addr,
    do_read,       // one-cycle sram read
    print_read     // capture byte, emit binary digits
  } parser_state_e;

  typedef enum logic [2:0] {
    menu,
    data_prompt,
    addr_prompt,
    read_prompt,
    write_ok
  } msg_id_e;

  // one queue entry, a message id or a literal byte
  typedef struct packed {
    logic       is_msg;
    logic [7:0] payload;
  } print_item_t;

  typedef struct packed {
    logic               en;
    logic               write;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
  } sram_req_t;

endpackage

// ==== logic/message_rom.sv ====
`timescale 1ns/1ps

module message_rom
  import sram_console_pkg::*;
(
  input  msg_id_e     msg,
  input  logic [3:0]  index,
  output logic [7:0]  char,
  output logic        last
);

  localparam logic [7:0] CR = 8'd13;

  // texts padded to 16 bytes, byte 0 is sent first
  localparam logic [0:15][7:0] MENU_TEXT  = {CR, "1-Write", CR, "2-Read", CR};
  localparam logic [0:15][7:0] DATA_TEXT  = {CR, "Data:", {10{8'h00}}};
  localparam logic [0:15][7:0] ADDR_TEXT  = {CR, "Addr:", {10{8'h00}}};
  localparam logic [0:15][7:0] READ_TEXT  = {CR, "Read addr:", {5{8'h00}}};
  localparam logic [0:15][7:0] OK_TEXT    = {CR, "OK", CR, {12{8'h00}}};

  localparam logic [3:0] MENU_LAST = 4'd15;
  localparam logic [3:0] DATA_LAST = 4'd5;
  localparam logic [3:0] ADDR_LAST = 4'd5;
  localparam logic [3:0] READ_LAST = 4'd10;
  localparam logic [3:0] OK_LAST   = 4'd3;

  always_comb
  begin
    case (msg)
      menu:
      begin
        char = MENU_TEXT[index];
        last = (index == MENU_LAST);
      end
      data_prompt:
      begin
        char = DATA_TEXT[index];
        last = (index == DATA_LAST);
      end
      addr_prompt:
      begin
        char = ADDR_TEXT[index];
        last = (index == ADDR_LAST);
      end
      read_prompt:
      begin
        char = READ_TEXT[index];
        last = (index == READ_LAST);
      end
      write_ok:
      begin
        char = OK_TEXT[index];
        last = (index == OK_LAST);
      end
      default:
      begin
        char = 8'h00;
        last = 1'b1;   // unknown id ends at once
      end
    endcase
  end

endmodule

// ==== logic/tx_queue.sv ====
`timescale 1ns/1ps
`include "sram_console_defs.svh"

module tx_queue
  import sram_console_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         push,
  input  print_item_t  item_in,
  input  logic         pop,
  output print_item_t  item_out,
  output logic         full,
  output logic         empty
);

  localparam int PTR_W = $clog2(`TXQ_DEPTH);
  localparam int CNT_W = $clog2(`TXQ_DEPTH + 1);

  print_item_t       buffer [`TXQ_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  assign full     = (count == CNT_W'(`TXQ_DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;   // overflow drops the item
  assign do_pop   = pop && !empty;
  assign item_out = buffer[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      buffer[wr_ptr] <= item_in;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;     // depth is a power of two, wraps
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// ==== logic/tx_streamer.sv ====
`timescale 1ns/1ps
`include "sram_console_defs.svh"

module tx_streamer
  import sram_console_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         empty,
  input  print_item_t  item,
  output logic         pop,
  input  logic         tx_ready,
  output logic         tx_start,
  output logic [7:0]   w_data
);

  localparam int HOLD_W = $clog2(`TX_HOLD + 1);

  logic [HOLD_W-1:0]  hold_cnt;
  logic [3:0]         idx;        // position inside a message
  msg_id_e            head_msg;
  logic [7:0]         rom_char;
  logic               rom_last;
  logic [7:0]         next_byte;
  logic               last_byte;
  logic               hold_done;
  logic               fire;

  assign head_msg = msg_id_e'(item.payload[2:0]);

  message_rom i_message_rom (
    .msg   (head_msg),
    .index (idx),
    .char  (rom_char),
    .last  (rom_last)
  );

  assign next_byte = item.is_msg ? rom_char : item.payload;
  assign last_byte = !item.is_msg || rom_last;   // literal is a single byte
  assign hold_done = (hold_cnt == HOLD_W'(`TX_HOLD));
  assign fire      = !empty && tx_ready && hold_done;
  assign pop       = fire && last_byte;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hold_cnt <= '0;
      idx      <= '0;
      tx_start <= 1'b0;
    end
    else
    begin
      tx_start <= fire;
      // a started character needs a fresh ready window
      if (!tx_ready || fire)
        hold_cnt <= '0;
      else if (!hold_done)
        hold_cnt <= hold_cnt + 1'b1;
      if (fire)
        idx <= last_byte ? '0 : idx + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fire)
      w_data <= next_byte;   // held until the next start
  end

endmodule

// ==== logic/command_parser.sv ====
`timescale 1ns/1ps
`include "sram_console_defs.svh"

module command_parser
  import sram_console_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         rx_done_tick,
  input  logic [7:0]   r_data,
  input  logic         full,
  output logic         push,
  output print_item_t  item,
  output sram_req_t    sram_req,
  input  logic [7:0]   data_s2f_r
);

  // one counter serves the entry fields and the read digits
  localparam int CNT_MAX = (`DIGITS > `DATA_W) ? `DIGITS : `DATA_W;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  parser_state_e       state;
  logic [CNT_W-1:0]    cnt;
  logic [`DATA_W-1:0]  data_val;
  logic [`DIGITS-1:0]  addr_val;
  logic [`DATA_W-1:0]  read_byte;
  logic                is_bit;

  assign is_bit = (r_data[7:1] == 7'h18);  // ascii "0" or "1"

  function automatic print_item_t msg_item(input msg_id_e id);
    print_item_t it;
    it.is_msg  = 1'b1;
    it.payload = 8'(id);
    return it;
  endfunction

  always_comb
  begin
    push           = 1'b0;
    item.is_msg    = 1'b0;
    item.payload   = r_data;                // echo by default
    sram_req.en    = 1'b0;
    sram_req.write = 1'b0;
    sram_req.addr  = {{(`ADDR_W - `DIGITS){1'b0}}, addr_val};
    sram_req.wdata = '0;
    case (state)
      show_menu:
      begin
        push = !full;
        item = msg_item(menu);
      end
      prompt_data:
      begin
        push = !full;
        item = msg_item(data_prompt);
      end
      prompt_addr:
      begin
        push = !full;
        item = msg_item(addr_prompt);
      end
      prompt_read:
      begin
        push = !full;
        item = msg_item(read_prompt);
      end
      get_data, get_addr, get_read_addr:
        push = rx_done_tick;                // rx cannot wait, so no full check
      do_write:
      begin
        push           = !full;
        item           = msg_item(write_ok);
        sram_req.en    = !full;             // fires on the cycle we leave
        sram_req.write = !full;
        sram_req.wdata = full ? '0 : data_val;
      end
      do_read:
        sram_req.en = 1'b1;
      print_read:
      begin
        push         = (cnt != '0) && !full;
        item.payload = {7'h18, read_byte[`DATA_W-1]};  // msb first
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= show_menu;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        show_menu:
          if (!full)
            state <= wait_option;
        wait_option:
          if (rx_done_tick)
          begin
            if (r_data == "1")
              state <= prompt_data;
            else if (r_data == "2")
              state <= prompt_read;
          end
        prompt_data, prompt_addr, prompt_read:
          if (!full)
          begin
            cnt <= '0;
            if (state == prompt_data)
              state <= get_data;
            else if (state == prompt_addr)
              state <= get_addr;
            else
              state <= get_read_addr;
          end
        get_data, get_addr, get_read_addr:
          if (rx_done_tick)
          begin
            cnt <= cnt + 1'b1;
            if (cnt == `DIGITS - 1)
            begin
              if (state == get_data)
                state <= prompt_addr;
              else if (state == get_addr)
                state <= do_write;
              else
                state <= do_read;
            end
          end
        do_write:
          if (!full)
            state <= show_menu;
        do_read:
        begin
          cnt   <= '0;
          state <= print_read;
        end
        print_read:
          if (cnt == '0)
            cnt <= cnt + 1'b1;              // sram byte lands this cycle
          else if (!full)
          begin
            cnt <= cnt + 1'b1;
            if (cnt == `DATA_W)
              state <= show_menu;
          end
        default:
          state <= show_menu;
      endcase
    end
  end

  // field values start from zero at each prompt
  always_ff @(posedge clk)
  begin
    case (state)
      prompt_data:
        if (!full)
          data_val <= '0;
      get_data:
        if (rx_done_tick && is_bit)
          data_val <= {data_val[`DATA_W-2:0], r_data[0]};
      prompt_addr, prompt_read:
        if (!full)
          addr_val <= '0;
      get_addr, get_read_addr:
        if (rx_done_tick && is_bit)
          addr_val <= {addr_val[`DIGITS-2:0], r_data[0]};
      print_read:
        if (cnt == '0)
          read_byte <= data_s2f_r;
        else if (!full)
          read_byte <= {read_byte[`DATA_W-2:0], 1'b0};
      default: ;
    endcase
  end

endmodule

// ==== logic/sram_console.sv ====
`timescale 1ns/1ps
`include "sram_console_defs.svh"

module sram_console
  import sram_console_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               rx_done_tick,
  input  logic [7:0]         r_data,
  input  logic               tx_ready,
  output logic [7:0]         w_data,
  output logic               tx_start,
  output logic               mem,
  output logic               rw,
  output logic [`ADDR_W-1:0] addr,
  output logic [7:0]         data_f2s,
  input  logic [7:0]         data_s2f_r
);

  logic         push;
  logic         pop;
  logic         full;
  logic         empty;
  print_item_t  item_in;
  print_item_t  item_out;
  sram_req_t    sram_req;

  command_parser i_command_parser (
    .clk          (clk),
    .reset        (reset),
    .rx_done_tick (rx_done_tick),
    .r_data       (r_data),
    .full         (full),
    .push         (push),
    .item         (item_in),
    .sram_req     (sram_req),
    .data_s2f_r   (data_s2f_r)
  );

  tx_queue i_tx_queue (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .item_in  (item_in),
    .pop      (pop),
    .item_out (item_out),
    .full     (full),
    .empty    (empty)
  );

  tx_streamer i_tx_streamer (
    .clk      (clk),
    .reset    (reset),
    .empty    (empty),
    .item     (item_out),
    .pop      (pop),
    .tx_ready (tx_ready),
    .tx_start (tx_start),
    .w_data   (w_data)
  );

  // sram pins, write is rw low
  assign mem      = sram_req.en;
  assign rw       = ~sram_req.write;
  assign addr     = sram_req.addr;
  assign data_f2s = sram_req.wdata;

endmodule

// ==== test/tb_sram_console.sv ====
`timescale 1ns/1ps
`include "sram_console_defs.svh"

module tb_sram_console;

  localparam int N_WRITES     = 4;
  localparam int N_FIELDS     = 16;  // entered fields over all commands
  localparam int N_CMDS       = 14;
  localparam int WATCH_CYCLES = N_FIELDS * `DIGITS * 400 + N_CMDS * 3000 + 4000;
  localparam logic [7:0] CR   = 8'd13;

  logic               clk;
  logic               reset;
  logic               rx_done_tick;
  logic [7:0]         r_data;
  logic               tx_ready;
  logic [7:0]         w_data;
  logic               tx_start;
  logic               mem;
  logic               rw;
  logic [`ADDR_W-1:0] addr;
  logic [7:0]         data_f2s;
  logic [7:0]         data_s2f_r;

  logic [7:0]          exp_q [$];
  logic [7:0]          rec_q [$];
  logic [7:0]          sram_mem [256];
  logic [7:0]          ref_mem [256];
  logic [`DIGITS*8-1:0] data_field;
  logic [`DIGITS*8-1:0] addr_field;
  logic [`DIGITS*8-1:0] wr_addr [N_WRITES];
  logic [31:0]         stim_lfsr = 32'd97201;
  logic [31:0]         gap_lfsr  = 32'd97201;
  int                  cmp_idx = 0;
  int                  err_cnt = 0;
  int                  monitor_errs = 0;
  int                  start_cnt = 0;
  int                  ready_run = 0;
  int                  mem_pulses = 0;
  int                  test_cnt = 0;
  int                  pass_cnt = 0;
  logic                start_seen = 1'b0;
  logic                mem_q = 1'b0;
  logic                read_pending = 1'b0;
  logic [7:0]          read_val;

  sram_console i_sram_console (
    .clk          (clk),
    .reset        (reset),
    .rx_done_tick (rx_done_tick),
    .r_data       (r_data),
    .tx_ready     (tx_ready),
    .w_data       (w_data),
    .tx_start     (tx_start),
    .mem          (mem),
    .rw           (rw),
    .addr         (addr),
    .data_f2s     (data_f2s),
    .data_s2f_r   (data_s2f_r)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic stim_bit();
    stim_lfsr = lfsr_next(stim_lfsr);
    return stim_lfsr[0];
  endfunction

  function automatic int ready_gap();
    int n;
    n = 0;
    for (int i = 0; i < 3; i++)
    begin
      gap_lfsr = lfsr_next(gap_lfsr);
      n = (n << 1) | gap_lfsr[0];
    end
    return n + 1;                    // 1 to 8 cycles low
  endfunction

  function automatic logic [7:0] field_char(input logic [`DIGITS*8-1:0] f, input int i);
    return f[(`DIGITS-1-i)*8 +: 8];   // first typed char in the top byte
  endfunction

  // only "0" and "1" shift in, everything else just counts
  function automatic logic [7:0] field_value(input logic [`DIGITS*8-1:0] f);
    logic [7:0] v;
    logic [7:0] c;
    v = '0;
    for (int i = 0; i < `DIGITS; i++)
    begin
      c = field_char(f, i);
      if (c == "0" || c == "1")
        v = {v[6:0], c[0]};
    end
    return v;
  endfunction

  function automatic void add_text(input string s);
    for (int i = 0; i < s.len(); i++)
      exp_q.push_back(s[i]);
  endfunction

  function automatic void add_field(input logic [`DIGITS*8-1:0] f);
    for (int i = 0; i < `DIGITS; i++)
      exp_q.push_back(field_char(f, i));   // echoes
  endfunction

  function automatic void add_menu();
    exp_q.push_back(CR);
    add_text("1-Write");
    exp_q.push_back(CR);
    add_text("2-Read");
    exp_q.push_back(CR);
  endfunction

  function automatic void expected_output(input logic [7:0] opt);
    logic [7:0] aval;
    logic [7:0] rb;
    aval = field_value(addr_field);
    if (opt == "1")
    begin
      exp_q.push_back(CR);
      add_text("Data:");
      add_field(data_field);
      exp_q.push_back(CR);
      add_text("Addr:");
      add_field(addr_field);
      exp_q.push_back(CR);
      add_text("OK");
      exp_q.push_back(CR);
      ref_mem[aval] = field_value(data_field);
      add_menu();
    end
    else if (opt == "2")
    begin
      exp_q.push_back(CR);
      add_text("Read addr:");
      add_field(addr_field);
      rb = ref_mem[aval];
      for (int i = 7; i >= 0; i--)
        exp_q.push_back(rb[i] ? "1" : "0");
      add_menu();
    end
  endfunction

  function automatic logic [`DIGITS*8-1:0] random_field(input logic mixed);
    logic [`DIGITS*8-1:0] f;
    logic [7:0]           others [4];
    int                   sel;
    others = '{"a", "2", "7", "#"};
    for (int i = 0; i < `DIGITS; i++)
    begin
      if (!mixed || stim_bit())
        f[(`DIGITS-1-i)*8 +: 8] = {7'b0011000, stim_bit()};
      else
      begin
        sel = {stim_bit(), stim_bit()};
        f[(`DIGITS-1-i)*8 +: 8] = others[sel];
      end
    end
    return f;
  endfunction

  // uart transmitter model
  always @(posedge clk)
  begin
    if (tx_start)
    begin
      rec_q.push_back(w_data);
      start_cnt++;
      // last sample counted is the edge that raised the pulse
      if (ready_run - 1 < `TX_HOLD)
      begin
        $display("Error at %0t: tx_start after tx_ready was high only %0d cycles",
                 $time, ready_run - 1);
        err_cnt++;
        monitor_errs++;
      end
      start_seen = 1'b1;
    end
    ready_run = tx_ready ? ready_run + 1 : 0;
  end

  initial
  begin
    int n;
    tx_ready = 1'b1;
    forever
    begin
      @(negedge clk);
      if (start_seen)
      begin
        start_seen = 1'b0;
        tx_ready   = 1'b0;         // busy sending the byte
        n          = ready_gap();
        repeat (n) @(negedge clk);
        tx_ready = 1'b1;
      end
    end
  end

  // compare each recorded byte with the reference stream
  always @(negedge clk)
  begin
    while (cmp_idx < rec_q.size())
    begin
      if (cmp_idx >= exp_q.size())
      begin
        $display("Error at %0t: w_data sent an extra byte %h", $time, rec_q[cmp_idx]);
        err_cnt++;
      end
      else if (rec_q[cmp_idx] !== exp_q[cmp_idx])
      begin
        $display("Error at %0t: w_data byte %0d expected %h, got %h",
                 $time, cmp_idx, exp_q[cmp_idx], rec_q[cmp_idx]);
        err_cnt++;
      end
      cmp_idx++;
    end
  end

  // sram model, 256 bytes
  always @(posedge clk)
  begin
    if (!reset)
    begin
      if ((!mem || rw) && data_f2s !== 8'h00)
      begin
        $display("Error at %0t: data_f2s expected 00 outside a write, got %h",
                 $time, data_f2s);
        err_cnt++;
      end
      if (mem)
      begin
        mem_pulses++;
        if (mem_q)
        begin
          $display("Error at %0t: mem stayed high for more than one cycle", $time);
          err_cnt++;
          monitor_errs++;
        end
        if (addr[`ADDR_W-1:8] != '0)
        begin
          $display("Error at %0t: addr upper bits expected 0, got %h", $time, addr);
          err_cnt++;
        end
        if (!rw)
          sram_mem[addr[7:0]] = data_f2s;
        else
        begin
          read_val     = sram_mem[addr[7:0]];
          read_pending = 1'b1;
        end
      end
      mem_q = mem;
    end
  end

  always @(negedge clk)
  begin
    if (read_pending)
    begin
      data_s2f_r   = read_val;       // valid the cycle after the request
      read_pending = 1'b0;
    end
  end

  initial
  begin
    repeat (WATCH_CYCLES) @(posedge clk);
    $display("watchdog ran out after %0d cycles, the console stopped responding",
             WATCH_CYCLES);
    $display("Test failures found");
    $finish;
  end

  task automatic send_char(input logic [7:0] c);
    @(negedge clk);
    rx_done_tick = 1'b1;
    r_data       = c;
    @(negedge clk);
    rx_done_tick = 1'b0;
    repeat (300) @(negedge clk);     // host spacing
  endtask

  task automatic send_field(input logic [`DIGITS*8-1:0] f);
    for (int i = 0; i < `DIGITS; i++)
      send_char(field_char(f, i));
  endtask

  task automatic drain_output();
    while (cmp_idx < exp_q.size())
      @(negedge clk);
    repeat (400) @(negedge clk);     // leaves room for stray bytes
  endtask

  task automatic run_command(input logic [7:0] opt);
    int mem_before;
    int mem_exp;
    exp_q.delete();
    rec_q.delete();
    cmp_idx    = 0;
    mem_before = mem_pulses;
    mem_exp    = (opt == "1" || opt == "2") ? 1 : 0;
    expected_output(opt);
    send_char(opt);
    if (opt == "1")
      send_field(data_field);
    if (opt == "1" || opt == "2")
      send_field(addr_field);
    drain_output();
    if (mem_pulses - mem_before != mem_exp)
    begin
      $display("Error at %0t: mem pulses for option %h expected %0d, got %0d",
               $time, opt, mem_exp, mem_pulses - mem_before);
      err_cnt++;
    end
  endtask

  task automatic check_stored();
    logic [7:0] a;
    logic [7:0] d;
    a = field_value(addr_field);
    d = field_value(data_field);
    if (sram_mem[a] !== d)
    begin
      $display("Error at %0t: sram_mem[%h] expected %h, got %h", $time, a, d, sram_mem[a]);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    test_cnt++;
    if (err_cnt == errs_at_start)
    begin
      pass_cnt++;
      $display("test %0d %s: ok", test_cnt, name);
    end
    else
      $display("test %0d %s: FAIL, %0d errors", test_cnt, name, err_cnt - errs_at_start);
  endtask

  initial
  begin
    int e;
    reset        = 1'b1;
    rx_done_tick = 1'b0;
    r_data       = 8'h00;
    data_s2f_r   = 8'h00;
    for (int i = 0; i < 256; i++)
    begin
      sram_mem[i] = 8'(i * 29 + 83);   // same fill in model and reference
      ref_mem[i]  = 8'(i * 29 + 83);
    end
    add_menu();
    repeat (10) @(negedge clk);
    e = err_cnt;
    if (tx_start !== 1'b0 || mem !== 1'b0 || rw !== 1'b1)
    begin
      $display("Error at %0t: reset outputs tx_start/mem/rw expected 0/0/1, got %b/%b/%b",
               $time, tx_start, mem, rw);
      err_cnt++;
    end
    reset = 1'b0;
    drain_output();
    end_test("menu after reset", e);

    e = err_cnt;
    for (int w = 0; w < N_WRITES; w++)
    begin
      data_field = random_field(1'b0);
      addr_field = random_field(1'b0);
      wr_addr[w] = addr_field;
      run_command("1");
      check_stored();
    end
    end_test("write random data", e);

    e = err_cnt;
    for (int w = 0; w < N_WRITES; w++)
    begin
      addr_field = wr_addr[w];
      run_command("2");
    end
    end_test("read back written bytes", e);

    e = err_cnt;
    data_field = random_field(1'b1);
    addr_field = random_field(1'b1);
    run_command("1");
    check_stored();
    run_command("2");
    end_test("mixed field characters", e);

    e = err_cnt;
    run_command("7");
    run_command("a");
    run_command("0");
    addr_field = wr_addr[0];
    run_command("2");
    end_test("ignored option bytes", e);

    test_cnt++;
    if (monitor_errs == 0 && start_cnt > 0)
    begin
      pass_cnt++;
      $display("test %0d tx pacing and mem pulse: ok, %0d starts", test_cnt, start_cnt);
    end
    else
    begin
      if (start_cnt == 0)
        err_cnt++;
      $display("test %0d tx pacing and mem pulse: FAIL, %0d monitor errors, %0d starts",
               test_cnt, monitor_errs, start_cnt);
    end

    $display("%0d tests, %0d ok, %0d failed, %0d errors",
             test_cnt, pass_cnt, test_cnt - pass_cnt, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+logic
logic/sram_console_pkg.sv
logic/message_rom.sv
logic/tx_queue.sv
logic/tx_streamer.sv
logic/command_parser.sv
logic/sram_console.sv
test/tb_sram_console.sv

// ==== Bender.yml ====
package:
  name: sram_console

sources:
  - include_dirs:
      - logic
    files:
      - logic/sram_console_pkg.sv
      - logic/message_rom.sv
      - logic/tx_queue.sv
      - logic/tx_streamer.sv
      - logic/command_parser.sv
      - logic/sram_console.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_sram_console.sv
